// File: design/core_defs.svh
// execute slice widths, operand mux bit positions and forwarding codes
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// ------------------------------------------------------------
// datapath widths
// ------------------------------------------------------------
`define XLEN 32
`define REG_W 5
`define L1D_SIZE_W 3

// enum encodings
`define ALU_OP_W 4
`define BRNCH_CND_W 3

// ------------------------------------------------------------
// operand select bus
// ------------------------------------------------------------
`define MUX_W 4
// operand a takes the immediate
`define MUX_SRC1_IMM 0
// operand b takes the pc
`define MUX_SRC2_PC 1
// address base is the pc instead of src1
`define MUX_ADDR_PC 2
// result comes from memory in the later stages
`define MUX_ALU_MEM 3

// forwarding select codes
`define FWD_W 2
`define FWD_RF 2'd0
`define FWD_MEM 2'd1
`define FWD_WB 2'd2

`endif

// File: design/core_pkg.sv
// execute slice types for alu ops, branch conditions, forwarding and stage payloads
`include "core_defs.svh"

package core_pkg;

	// ------------------------------------------------------------
	// operation encodings
	// ------------------------------------------------------------
	typedef enum logic [`ALU_OP_W-1:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	// none means never taken
	typedef enum logic [`BRNCH_CND_W-1:0] {
		cnd_none = 3'd0,
		cnd_eq   = 3'd1,
		cnd_ne   = 3'd2,
		cnd_lt   = 3'd3,
		cnd_ge   = 3'd4,
		cnd_ltu  = 3'd5,
		cnd_geu  = 3'd6
	} brnch_cnd_e;

	// operand source after bypass
	typedef enum logic [`FWD_W-1:0] {
		fwd_rf  = `FWD_RF,
		fwd_mem = `FWD_MEM,
		fwd_wb  = `FWD_WB
	} fwd_sel_e;

	// ------------------------------------------------------------
	// stage payloads
	// ------------------------------------------------------------
	typedef struct packed {
		logic                   valid;
		logic                   we;
		logic [`REG_W-1:0]      rd;
		logic [`REG_W-1:0]      rs1;
		logic [`REG_W-1:0]      rs2;
		alu_op_e                alu_op;
		brnch_cnd_e             brnch_cnd;
		logic [`MUX_W-1:0]      mux;
		logic                   l1d_val;
		logic [`L1D_SIZE_W-1:0] l1d_size;
		logic [`XLEN-1:0]       src1;
		logic [`XLEN-1:0]       src2;
		logic [`XLEN-1:0]       pc;
		logic [`XLEN-1:0]       imm;
	} id_ex_t;

	// all zero is a bubble
	typedef struct packed {
		logic                   valid;
		logic                   we;
		logic [`REG_W-1:0]      rd;
		logic                   alu_mem;
		logic                   brnch_taken;
		logic [`XLEN-1:0]       alu_result;
		logic [`XLEN-1:0]       addr;
		logic [`XLEN-1:0]       wdata;
		logic                   l1d_val;
		logic [`L1D_SIZE_W-1:0] l1d_size;
	} ex_mem_t;

endpackage

// File: design/core_byp_if.sv
// operand bypass bundle between the forwarding unit and the execute station
`timescale 1ns/1ns
`include "core_defs.svh"

interface core_byp_if;

	// per-operand source select
	core_pkg::fwd_sel_e sel1;
	core_pkg::fwd_sel_e sel2;

	// candidate bypass values
	// memory stage result
	logic [`XLEN-1:0] m_data;
	// writeback stage result
	logic [`XLEN-1:0] w_data;

	// forwarding unit side
	modport fwd (
		output sel1,
		output sel2,
		output m_data,
		output w_data
	);

	// execute station side
	modport exe (
		input sel1,
		input sel2,
		input m_data,
		input w_data
	);

endinterface

// File: design/core_stage_reg.sv
// pipeline stage register with hold, bubble insertion and async clear
`timescale 1ns/1ns

module core_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	// advance the stage
	input  logic     enb,
	// replace incoming entry with a bubble
	input  logic     kill,
	input  payload_t d,
	output payload_t q
);

	// ------------------------------------------------------------
	// stage state
	// ------------------------------------------------------------
	// zero payload doubles as the bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (enb) begin
			if (kill) begin
				q <= '0;
			end else begin
				q <= d;
			end
		end
		// enb low holds
	end

endmodule

// File: design/core_fwd_unit.sv
// forwarding unit selecting memory, writeback or register file operands
`timescale 1ns/1ns
`include "core_defs.svh"

module core_fwd_unit (
	// sources of the instruction in execute
	input  logic [`REG_W-1:0] rs1,
	input  logic [`REG_W-1:0] rs2,
	// older instruction sitting in ex/mem
	input  core_pkg::ex_mem_t m_entry,
	// writeback port
	input  logic              w_we,
	input  logic [`REG_W-1:0] w_rd,
	input  logic [`XLEN-1:0]  w_data,
	core_byp_if.fwd           byp
);

	logic m_hit_ok;
	logic w_hit_ok;

	// ------------------------------------------------------------
	// producer qualification
	// ------------------------------------------------------------
	// x0 never forwards
	assign m_hit_ok = m_entry.valid && m_entry.we && (m_entry.rd != '0);
	assign w_hit_ok = w_we && (w_rd != '0);

	// memory stage wins over writeback
	function automatic core_pkg::fwd_sel_e pick_src(
		input logic [`REG_W-1:0] rs,
		input logic              m_ok,
		input logic [`REG_W-1:0] m_rd,
		input logic              w_ok,
		input logic [`REG_W-1:0] wb_rd
	);
		if (m_ok && (m_rd == rs)) begin
			return core_pkg::fwd_mem;
		end else if (w_ok && (wb_rd == rs)) begin
			return core_pkg::fwd_wb;
		end
		return core_pkg::fwd_rf;
	endfunction

	assign byp.sel1 = pick_src(rs1, m_hit_ok, m_entry.rd, w_hit_ok, w_rd);
	assign byp.sel2 = pick_src(rs2, m_hit_ok, m_entry.rd, w_hit_ok, w_rd);

	// bypass data
	// registered alu result of ex/mem
	assign byp.m_data = m_entry.alu_result;
	assign byp.w_data = w_data;

endmodule

// File: design/core_alu.sv
// integer alu with branch condition compare
`timescale 1ns/1ns
`include "core_defs.svh"

module core_alu (
	input  logic [`XLEN-1:0]   src1,
	input  logic [`XLEN-1:0]   src2,
	input  core_pkg::alu_op_e  alu_op,
	input  core_pkg::brnch_cnd_e brnch_cnd,
	output logic [`XLEN-1:0]   alu_result,
	output logic               brnch_taken
);

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       eq;

	// only the low bits shift
	assign shamt = src2[4:0];

	// shared compare results
	assign lt_s = $signed(src1) < $signed(src2);
	assign lt_u = src1 < src2;
	assign eq   = src1 == src2;

	// ------------------------------------------------------------
	// arithmetic and logic
	// ------------------------------------------------------------
	always_comb begin
		case (alu_op)
			core_pkg::alu_add:    alu_result = src1 + src2;
			core_pkg::alu_sub:    alu_result = src1 - src2;
			core_pkg::alu_sll:    alu_result = src1 << shamt;
			core_pkg::alu_slt:    alu_result = {{(`XLEN-1){1'b0}}, lt_s};
			core_pkg::alu_sltu:   alu_result = {{(`XLEN-1){1'b0}}, lt_u};
			core_pkg::alu_xor:    alu_result = src1 ^ src2;
			core_pkg::alu_srl:    alu_result = src1 >> shamt;
			// arithmetic shift keeps the sign
			core_pkg::alu_sra:    alu_result = $signed(src1) >>> shamt;
			core_pkg::alu_or:     alu_result = src1 | src2;
			core_pkg::alu_and:    alu_result = src1 & src2;
			// lui style move of operand b
			core_pkg::alu_pass_b: alu_result = src2;
			default:              alu_result = '0;
		endcase
	end

	// ------------------------------------------------------------
	// branch condition
	// ------------------------------------------------------------
	always_comb begin
		case (brnch_cnd)
			core_pkg::cnd_eq:  brnch_taken = eq;
			core_pkg::cnd_ne:  brnch_taken = !eq;
			core_pkg::cnd_lt:  brnch_taken = lt_s;
			core_pkg::cnd_ge:  brnch_taken = !lt_s;
			core_pkg::cnd_ltu: brnch_taken = lt_u;
			core_pkg::cnd_geu: brnch_taken = !lt_u;
			// none and unused codes
			default:           brnch_taken = 1'b0;
		endcase
	end

endmodule

// File: design/core_exe_s.sv
// execute station with bypass muxes, alu, address adder and ex/mem assembly
`timescale 1ns/1ns
`include "core_defs.svh"

module core_exe_s (
	// registered id/ex entry
	input  core_pkg::id_ex_t  id,
	core_byp_if.exe           byp,
	// next ex/mem entry
	output core_pkg::ex_mem_t ex
);

	logic [`XLEN-1:0] fwd_src1;
	logic [`XLEN-1:0] fwd_src2;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] addr_base;
	logic [`XLEN-1:0] addr;
	logic [`XLEN-1:0] alu_result;
	logic             brnch_taken;

	// ------------------------------------------------------------
	// operand bypass
	// ------------------------------------------------------------
	function automatic logic [`XLEN-1:0] byp_mux(
		input core_pkg::fwd_sel_e sel,
		input logic [`XLEN-1:0]   rf_val,
		input logic [`XLEN-1:0]   m_val,
		input logic [`XLEN-1:0]   w_val
	);
		case (sel)
			core_pkg::fwd_mem: return m_val;
			core_pkg::fwd_wb:  return w_val;
			default:           return rf_val;
		endcase
	endfunction

	// each source uses its own select
	assign fwd_src1 = byp_mux(byp.sel1, id.src1, byp.m_data, byp.w_data);
	assign fwd_src2 = byp_mux(byp.sel2, id.src2, byp.m_data, byp.w_data);

	// immediate or pc operands
	assign op_a = id.mux[`MUX_SRC1_IMM] ? id.imm : fwd_src1;
	assign op_b = id.mux[`MUX_SRC2_PC] ? id.pc : fwd_src2;

	core_alu u_alu (
		.src1        (op_a),
		.src2        (op_b),
		.alu_op      (id.alu_op),
		.brnch_cnd   (id.brnch_cnd),
		.alu_result  (alu_result),
		.brnch_taken (brnch_taken)
	);

	// ------------------------------------------------------------
	// load/store and jump target
	// ------------------------------------------------------------
	// pc relative or register relative
	assign addr_base = id.mux[`MUX_ADDR_PC] ? id.pc : fwd_src1;
	assign addr      = id.imm + addr_base;

	// ------------------------------------------------------------
	// ex/mem payload
	// ------------------------------------------------------------
	always_comb begin
		ex             = '0;
		ex.valid       = id.valid;
		ex.we          = id.we;
		ex.rd          = id.rd;
		ex.alu_mem     = id.mux[`MUX_ALU_MEM];
		ex.brnch_taken = brnch_taken;
		ex.alu_result  = alu_result;
		ex.addr        = addr;
		// store data follows the bypassed rs2
		ex.wdata       = fwd_src2;
		ex.l1d_val     = id.l1d_val;
		ex.l1d_size    = id.l1d_size;
	end

endmodule

// File: design/core_exe_top.sv
// execute slice top with id/ex, execute station, forwarding and ex/mem
`timescale 1ns/1ns
`include "core_defs.svh"

module core_exe_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enb,
	input  logic                   kill,
	// decoded instruction
	input  logic                   in_val,
	input  logic                   in_we,
	input  logic [`REG_W-1:0]      in_rd,
	input  logic [`REG_W-1:0]      in_rs1,
	input  logic [`REG_W-1:0]      in_rs2,
	input  logic [3:0]             in_alu_op,
	input  logic [2:0]             in_brnch_cnd,
	input  logic [`MUX_W-1:0]      in_mux,
	input  logic                   in_l1d_val,
	input  logic [`L1D_SIZE_W-1:0] in_l1d_size,
	input  logic [`XLEN-1:0]       in_src1,
	input  logic [`XLEN-1:0]       in_src2,
	input  logic [`XLEN-1:0]       in_pc,
	input  logic [`XLEN-1:0]       in_imm,
	// writeback stage
	input  logic                   w_we,
	input  logic [`REG_W-1:0]      w_rd,
	input  logic [`XLEN-1:0]       w_data,
	// ex/mem contents
	output logic                   out_val,
	output logic                   out_we,
	output logic [`REG_W-1:0]      out_rd,
	output logic                   out_alu_mem,
	output logic                   out_brnch_taken,
	output logic [`XLEN-1:0]       out_alu_result,
	output logic [`XLEN-1:0]       out_addr,
	output logic [`XLEN-1:0]       out_wdata,
	output logic                   out_l1d_val,
	output logic [`L1D_SIZE_W-1:0] out_l1d_size
);

	core_pkg::id_ex_t  id_d;
	core_pkg::id_ex_t  id_q;
	core_pkg::ex_mem_t ex_d;
	core_pkg::ex_mem_t ex_q;

	// ------------------------------------------------------------
	// id/ex input packing
	// ------------------------------------------------------------
	assign id_d.valid     = in_val;
	assign id_d.we        = in_we;
	assign id_d.rd        = in_rd;
	assign id_d.rs1       = in_rs1;
	assign id_d.rs2       = in_rs2;
	assign id_d.alu_op    = core_pkg::alu_op_e'(in_alu_op);
	assign id_d.brnch_cnd = core_pkg::brnch_cnd_e'(in_brnch_cnd);
	assign id_d.mux       = in_mux;
	assign id_d.l1d_val   = in_l1d_val;
	assign id_d.l1d_size  = in_l1d_size;
	assign id_d.src1      = in_src1;
	assign id_d.src2      = in_src2;
	assign id_d.pc        = in_pc;
	assign id_d.imm       = in_imm;

	// no squash at this stage
	core_stage_reg #(.payload_t(core_pkg::id_ex_t)) u_id_ex (
		.clk   (clk),
		.rst_n (rst_n),
		.enb   (enb),
		.kill  (1'b0),
		.d     (id_d),
		.q     (id_q)
	);

	core_byp_if u_byp ();

	// compares against the older ex/mem entry
	core_fwd_unit u_fwd (
		.rs1     (id_q.rs1),
		.rs2     (id_q.rs2),
		.m_entry (ex_q),
		.w_we    (w_we),
		.w_rd    (w_rd),
		.w_data  (w_data),
		.byp     (u_byp.fwd)
	);

	core_exe_s u_exe (
		.id  (id_q),
		.byp (u_byp.exe),
		.ex  (ex_d)
	);

	// kill turns the entering instruction into a bubble
	core_stage_reg #(.payload_t(core_pkg::ex_mem_t)) u_ex_mem (
		.clk   (clk),
		.rst_n (rst_n),
		.enb   (enb),
		.kill  (kill),
		.d     (ex_d),
		.q     (ex_q)
	);

	// ------------------------------------------------------------
	// output unpacking
	// ------------------------------------------------------------
	assign out_val         = ex_q.valid;
	assign out_we          = ex_q.we;
	assign out_rd          = ex_q.rd;
	assign out_alu_mem     = ex_q.alu_mem;
	assign out_brnch_taken = ex_q.brnch_taken;
	assign out_alu_result  = ex_q.alu_result;
	assign out_addr        = ex_q.addr;
	assign out_wdata       = ex_q.wdata;
	assign out_l1d_val     = ex_q.l1d_val;
	assign out_l1d_size    = ex_q.l1d_size;

endmodule

// File: dv/core_exe_checker.sv
// execute slice checker for reset clear, kill bubbles and stall hold
`timescale 1ns/1ns
`include "core_defs.svh"

module core_exe_checker (
	input logic               clk,
	input logic               rst_n,
	input logic               enb,
	input logic               kill,
	input logic               out_val,
	input logic               out_we,
	input logic               out_l1d_val,
	input logic [`REG_W-1:0]  out_rd,
	input logic [`XLEN-1:0]   out_alu_result,
	input logic [`XLEN-1:0]   out_addr,
	input logic [`XLEN-1:0]   out_wdata
);

	// failed assertion count, read by the testbench
	int fail_cnt;

	initial fail_cnt = 0;

	// ------------------------------------------------------------
	// assertions
	// ------------------------------------------------------------
	// first edge after release still sees the cleared entry
	a_reset_clear: assert property (@(posedge clk)
		$rose(rst_n) |-> (!out_val && !out_we && !out_l1d_val))
		else begin
			fail_cnt++;
			$error("ex/mem entry not cleared by reset");
		end

	// squashed entry carries no side effects
	a_kill_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		(enb && kill) |=> (!out_val && !out_we && !out_l1d_val))
		else begin
			fail_cnt++;
			$error("kill did not produce a bubble");
		end

	// stall holds the whole ex/mem entry
	a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!enb |=> ($stable(out_val) && $stable(out_we) && $stable(out_rd)
			&& $stable(out_alu_result) && $stable(out_addr) && $stable(out_wdata)))
		else begin
			fail_cnt++;
			$error("outputs changed while enb was low");
		end

endmodule

bind core_exe_top core_exe_checker u_chk (
	.clk            (clk),
	.rst_n          (rst_n),
	.enb            (enb),
	.kill           (kill),
	.out_val        (out_val),
	.out_we         (out_we),
	.out_l1d_val    (out_l1d_val),
	.out_rd         (out_rd),
	.out_alu_result (out_alu_result),
	.out_addr       (out_addr),
	.out_wdata      (out_wdata)
);

// File: dv/core_exe_tb.sv
// directed testbench for the execute slice against a two-stage reference model
`timescale 1ns/1ns
`include "core_defs.svh"

module core_exe_tb;

	localparam int PERIOD = 8;
	localparam int N_TESTS = 6;
	localparam int CYCLES_PER_TEST = 60;

	logic                   clk;
	logic                   rst_n;
	logic                   enb;
	logic                   kill;
	logic                   w_we;
	logic [`REG_W-1:0]      w_rd;
	logic [`XLEN-1:0]       w_data;
	// instruction presented at the inputs
	core_pkg::id_ex_t       cur;
	logic                   out_val;
	logic                   out_we;
	logic [`REG_W-1:0]      out_rd;
	logic                   out_alu_mem;
	logic                   out_brnch_taken;
	logic [`XLEN-1:0]       out_alu_result;
	logic [`XLEN-1:0]       out_addr;
	logic [`XLEN-1:0]       out_wdata;
	logic                   out_l1d_val;
	logic [`L1D_SIZE_W-1:0] out_l1d_size;
	// model pipeline image
	core_pkg::id_ex_t       m_id;
	core_pkg::ex_mem_t      m_ex;
	logic [15:0]            lfsr;
	int                     errors;

	core_exe_top uut (
		.clk (clk), .rst_n (rst_n), .enb (enb), .kill (kill),
		.in_val (cur.valid), .in_we (cur.we), .in_rd (cur.rd),
		.in_rs1 (cur.rs1), .in_rs2 (cur.rs2), .in_alu_op (cur.alu_op),
		.in_brnch_cnd (cur.brnch_cnd), .in_mux (cur.mux),
		.in_l1d_val (cur.l1d_val), .in_l1d_size (cur.l1d_size),
		.in_src1 (cur.src1), .in_src2 (cur.src2), .in_pc (cur.pc), .in_imm (cur.imm),
		.w_we (w_we), .w_rd (w_rd), .w_data (w_data),
		.out_val (out_val), .out_we (out_we), .out_rd (out_rd),
		.out_alu_mem (out_alu_mem), .out_brnch_taken (out_brnch_taken),
		.out_alu_result (out_alu_result), .out_addr (out_addr),
		.out_wdata (out_wdata), .out_l1d_val (out_l1d_val), .out_l1d_size (out_l1d_size)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [`XLEN-1:0] rand_word(input int nbits);
		logic [`XLEN-1:0] w;
		w = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[`XLEN-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic logic [`REG_W-1:0] rand_reg();
		logic [`XLEN-1:0] w;
		w = rand_word(`REG_W);
		return w[`REG_W-1:0];
	endfunction

	function automatic core_pkg::id_ex_t make_inst(input core_pkg::alu_op_e op,
		input logic [`REG_W-1:0] rd, input logic [`REG_W-1:0] rs1,
		input logic [`REG_W-1:0] rs2);
		core_pkg::id_ex_t t;
		t = '0;
		t.valid = 1'b1;
		t.we = 1'b1;
		t.rd = rd;
		t.rs1 = rs1;
		t.rs2 = rs2;
		t.alu_op = op;
		t.src1 = rand_word(`XLEN);
		t.src2 = rand_word(`XLEN);
		t.pc = rand_word(`XLEN);
		t.imm = rand_word(`XLEN);
		return t;
	endfunction

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	// memory stage first, then writeback, never x0
	function automatic logic [`XLEN-1:0] fwd_val(input logic [`REG_W-1:0] rs,
		input logic [`XLEN-1:0] rf);
		if (m_ex.valid && m_ex.we && (m_ex.rd != 0) && (m_ex.rd == rs)) begin
			return m_ex.alu_result;
		end
		if (w_we && (w_rd != 0) && (w_rd == rs)) begin
			return w_data;
		end
		return rf;
	endfunction

	function automatic core_pkg::ex_mem_t model_exe(input core_pkg::id_ex_t id);
		core_pkg::ex_mem_t r;
		logic [`XLEN-1:0]  s1;
		logic [`XLEN-1:0]  s2;
		logic [`XLEN-1:0]  a;
		logic [`XLEN-1:0]  b;
		int                sh;
		s1 = fwd_val(id.rs1, id.src1);
		s2 = fwd_val(id.rs2, id.src2);
		a = id.mux[`MUX_SRC1_IMM] ? id.imm : s1;
		b = id.mux[`MUX_SRC2_PC] ? id.pc : s2;
		sh = b[4:0];
		r = '0;
		r.valid = id.valid;
		r.we = id.we;
		r.rd = id.rd;
		r.alu_mem = id.mux[`MUX_ALU_MEM];
		r.l1d_val = id.l1d_val;
		r.l1d_size = id.l1d_size;
		r.wdata = s2;
		r.addr = id.imm + (id.mux[`MUX_ADDR_PC] ? id.pc : s1);
		case (id.alu_op)
			core_pkg::alu_add:    r.alu_result = a + b;
			core_pkg::alu_sub:    r.alu_result = a - b;
			core_pkg::alu_sll:    r.alu_result = a << sh;
			core_pkg::alu_slt:    r.alu_result = {31'd0, $signed(a) < $signed(b)};
			core_pkg::alu_sltu:   r.alu_result = {31'd0, a < b};
			core_pkg::alu_xor:    r.alu_result = a ^ b;
			core_pkg::alu_srl:    r.alu_result = a >> sh;
			// sign fill above the shifted bits
			core_pkg::alu_sra:    r.alu_result = (a >> sh) | ({32{a[31]}} << (32 - sh));
			core_pkg::alu_or:     r.alu_result = a | b;
			core_pkg::alu_and:    r.alu_result = a & b;
			core_pkg::alu_pass_b: r.alu_result = b;
			default:              r.alu_result = '0;
		endcase
		case (id.brnch_cnd)
			core_pkg::cnd_eq:  r.brnch_taken = (a == b);
			core_pkg::cnd_ne:  r.brnch_taken = (a != b);
			core_pkg::cnd_lt:  r.brnch_taken = ($signed(a) < $signed(b));
			core_pkg::cnd_ge:  r.brnch_taken = ($signed(a) >= $signed(b));
			core_pkg::cnd_ltu: r.brnch_taken = (a < b);
			core_pkg::cnd_geu: r.brnch_taken = (a >= b);
			default:           r.brnch_taken = 1'b0;
		endcase
		return r;
	endfunction

	// ------------------------------------------------------------
	// checking and sequencing
	// ------------------------------------------------------------
	task automatic compare(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
		input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		compare(out_val, m_ex.valid, "out_val");
		compare(out_we, m_ex.we, "out_we");
		compare(out_rd, m_ex.rd, "out_rd");
		compare(out_alu_mem, m_ex.alu_mem, "out_alu_mem");
		compare(out_brnch_taken, m_ex.brnch_taken, "out_brnch_taken");
		compare(out_alu_result, m_ex.alu_result, "out_alu_result");
		compare(out_addr, m_ex.addr, "out_addr");
		compare(out_wdata, m_ex.wdata, "out_wdata");
		compare(out_l1d_val, m_ex.l1d_val, "out_l1d_val");
		compare(out_l1d_size, m_ex.l1d_size, "out_l1d_size");
	endtask

	// model advances on the same edge as the dut, inputs change 1 ns later
	task automatic cycle();
		core_pkg::ex_mem_t nx;
		@(posedge clk);
		nx = model_exe(m_id);
		if (enb) begin
			m_ex = kill ? '0 : nx;
			m_id = cur;
		end
		#1;
		check_outputs();
	endtask

	task automatic issue(input core_pkg::id_ex_t t);
		cur = t;
		cycle();
	endtask

	task automatic issue_wb(input core_pkg::id_ex_t t, input logic we,
		input logic [`REG_W-1:0] rd, input logic [`XLEN-1:0] data);
		w_we = we;
		w_rd = rd;
		w_data = data;
		issue(t);
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		m_id = '0;
		m_ex = '0;
		repeat (4) @(posedge clk);
		#1;
		compare(out_val, 0, "out_val in reset");
		compare(out_we, 0, "out_we in reset");
		compare(out_l1d_val, 0, "out_l1d_val in reset");
		rst_n = 1'b1;
	endtask

	// ------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------
	task automatic test_alu_ops();
		core_pkg::id_ex_t t;
		for (int i = 0; i < 22; i++) begin
			t = make_inst(core_pkg::alu_op_e'(i % 11), rand_reg(), rand_reg(), rand_reg());
			t.brnch_cnd = core_pkg::brnch_cnd_e'(i % 7);
			// equal operands for eq/ge style compares
			if (i % 5 == 4) t.src2 = t.src1;
			issue(t);
		end
		issue('0);
		issue('0);
	endtask

	task automatic test_operand_sel();
		core_pkg::id_ex_t t;
		t = make_inst(core_pkg::alu_add, 5'd14, 5'd0, 5'd0);
		t.mux[`MUX_SRC1_IMM] = 1'b1;
		issue(t);
		t = make_inst(core_pkg::alu_sub, 5'd15, 5'd0, 5'd0);
		t.mux[`MUX_SRC2_PC] = 1'b1;
		issue(t);
		// load off rs1
		t = make_inst(core_pkg::alu_add, 5'd16, 5'd3, 5'd0);
		t.mux[`MUX_ALU_MEM] = 1'b1;
		t.l1d_val = 1'b1;
		t.l1d_size = 3'd2;
		issue(t);
		// store off the pc
		t = make_inst(core_pkg::alu_add, 5'd0, 5'd3, 5'd8);
		t.we = 1'b0;
		t.mux[`MUX_ADDR_PC] = 1'b1;
		t.l1d_val = 1'b1;
		t.l1d_size = 3'd1;
		issue(t);
		issue('0);
		issue('0);
	endtask

	// w port values apply to the entry already in id/ex
	task automatic test_forwarding();
		issue(make_inst(core_pkg::alu_add, 5'd5, 5'd0, 5'd0));
		issue(make_inst(core_pkg::alu_sub, 5'd3, 5'd5, 5'd5));
		issue(make_inst(core_pkg::alu_xor, 5'd9, 5'd0, 5'd7));
		// writeback hit on rs2
		issue_wb(make_inst(core_pkg::alu_or, 5'd0, 5'd9, 5'd9), 1'b1, 5'd7, rand_word(32));
		// both stages match rd 9
		issue_wb(make_inst(core_pkg::alu_and, 5'd4, 5'd0, 5'd0), 1'b1, 5'd9, rand_word(32));
		// rd zero in ex/mem and writeback
		issue_wb('0, 1'b1, 5'd0, rand_word(32));
		issue_wb('0, 1'b0, 5'd0, '0);
	endtask

	task automatic test_stall();
		issue(make_inst(core_pkg::alu_add, 5'd4, 5'd0, 5'd0));
		issue(make_inst(core_pkg::alu_or, 5'd6, 5'd4, 5'd0));
		enb = 1'b0;
		// inputs move while both stages hold
		repeat (5) begin
			issue_wb(make_inst(core_pkg::alu_sub, 5'd7, 5'd4, 5'd6), 1'b1, 5'd4, rand_word(32));
		end
		enb = 1'b1;
		issue_wb('0, 1'b0, 5'd0, '0);
		issue('0);
	endtask

	task automatic test_kill();
		core_pkg::id_ex_t t;
		t = make_inst(core_pkg::alu_add, 5'd10, 5'd0, 5'd0);
		t.l1d_val = 1'b1;
		issue(t);
		kill = 1'b1;
		issue(make_inst(core_pkg::alu_xor, 5'd11, 5'd10, 5'd0));
		kill = 1'b0;
		compare(out_val, 0, "killed out_val");
		compare(out_l1d_val, 0, "killed out_l1d_val");
		// follower sees no bypass from the bubble
		issue('0);
		compare(out_val, 1, "out_val behind kill");
		issue('0);
	endtask

	task automatic test_reset_mid();
		issue(make_inst(core_pkg::alu_and, 5'd12, 5'd0, 5'd0));
		issue(make_inst(core_pkg::alu_sll, 5'd13, 5'd12, 5'd0));
		apply_reset();
		issue(make_inst(core_pkg::alu_sra, 5'd2, 5'd0, 5'd0));
		issue('0);
		issue('0);
	endtask

	// ------------------------------------------------------------
	// main sequence and watchdog
	// ------------------------------------------------------------
	initial begin
		rst_n = 1'b0;
		enb = 1'b1;
		kill = 1'b0;
		w_we = 1'b0;
		w_rd = '0;
		w_data = '0;
		cur = '0;
		m_id = '0;
		m_ex = '0;
		lfsr = 16'd59257;
		errors = 0;
		apply_reset();
		test_alu_ops();
		test_operand_sel();
		test_forwarding();
		test_stall();
		test_kill();
		test_reset_mid();
		$display("run done: %0d value errors, %0d assertion errors",
			errors, uut.u_chk.fail_cnt);
		if ((errors == 0) && (uut.u_chk.fail_cnt == 0)) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(N_TESTS * CYCLES_PER_TEST * PERIOD);
		$display("timeout: the tests did not finish in %0d ns",
			N_TESTS * CYCLES_PER_TEST * PERIOD);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: project.f
+incdir+design
design/core_pkg.sv
design/core_byp_if.sv
design/core_stage_reg.sv
design/core_fwd_unit.sv
design/core_alu.sv
design/core_exe_s.sv
design/core_exe_top.sv
dv/core_exe_checker.sv
dv/core_exe_tb.sv
